//--- design/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ======================================================================
// Fetch front end sizing
// ======================================================================

// Address width of the fetch path
`define FETCH_XLEN 32

// Instruction memory depth in 32-bit words
// Indexed by PC bits above bit 1
`define IMEM_WORDS 256

// Direct-mapped BTB depth, power of two
`define BTB_ENTRIES 16

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- design/rv_isa_pkg.sv
`include "fetch_params.svh"

package rv_isa_pkg;

  // ====================================================================
  // ISA-level word types
  // ====================================================================

  // One 32-bit instruction word
  // Compressed encodings are not handled by this front end
  typedef logic [31:0] instr_t;

  // Byte address, width set by the fetch parameters
  typedef logic [`FETCH_XLEN-1:0] addr_t;

  // ====================================================================
  // Fixed encodings
  // ====================================================================

  // addi x0, x0, 0
  // Bubble placed in the IF/ID register on flush and reset
  localparam instr_t I_NOP = 32'h0000_0013;

endpackage

//--- design/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

  // ====================================================================
  // BTB geometry
  // ====================================================================

  // Index bits sit just above the two byte-offset bits
  localparam int BTB_IDX_W = $clog2(`BTB_ENTRIES);
  // Tag is every PC bit above the index
  localparam int BTB_TAG_W = `FETCH_XLEN - BTB_IDX_W - 2;

  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  // One stored BTB line
  typedef struct packed {
    logic              valid;
    btb_tag_t          tag;
    rv_isa_pkg::addr_t target;
    logic              taken;
    // Kept as a flag only, no return stack behind it
    logic              is_return;
  } btb_entry_t;

  // Prediction metadata carried alongside a fetched instruction
  typedef struct packed {
    logic              hit;
    logic              taken;
    rv_isa_pkg::addr_t target;
    logic              is_return;
  } pred_t;

  // Slice helpers so lookup and update agree on the PC split
  function automatic btb_idx_t btb_index(input rv_isa_pkg::addr_t addr);
    return addr[BTB_IDX_W+1:2];
  endfunction

  function automatic btb_tag_t btb_tag(input rv_isa_pkg::addr_t addr);
    return addr[`FETCH_XLEN-1:BTB_IDX_W+2];
  endfunction

endpackage

//--- design/pred_if.sv
`timescale 1ns/1ns

interface pred_if;
  import rv_isa_pkg::*;

  // BTB answer for the address looked up one cycle earlier
  logic  hit;
  logic  pred_taken;
  addr_t target;
  logic  is_return;

  // Producer side, registered in the BTB
  modport btb (
    output hit,
    output pred_taken,
    output target,
    output is_return
  );

  // Consumer side, folded into the IF/ID register
  modport if_stage (
    input hit,
    input pred_taken,
    input target,
    input is_return
  );

endinterface

//--- design/fetch_pc.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_pc (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ready,
  input  logic              redirect,
  input  rv_isa_pkg::addr_t redirect_pc,
  output rv_isa_pkg::addr_t pc,
  output logic              arvalid
);
  import rv_isa_pkg::*;

  addr_t pc_next;

  // ====================================================================
  // Next PC select
  // ====================================================================

  // Redirect wins over everything, even a stalled decode
  // Otherwise step one word per accepted fetch
  always_comb begin
    pc_next = pc;
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (ready) begin
      pc_next = pc + addr_t'(4);
    end
  end

  // ====================================================================
  // PC register
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // Fetch strobe follows downstream ready
  // Memory and BTB see the current PC whenever this is high
  assign arvalid = ready;

endmodule

//--- design/instr_mem.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module instr_mem (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               arvalid,
  input  rv_isa_pkg::addr_t  araddr,
  output rv_isa_pkg::instr_t rdata,
  output logic               rvalid,
  input  logic               wr_en,
  input  rv_isa_pkg::addr_t  wr_addr,
  input  rv_isa_pkg::instr_t wr_data
);
  import rv_isa_pkg::*;

  localparam int IDX_W = $clog2(`IMEM_WORDS);

  instr_t           mem [`IMEM_WORDS];
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  // Word index, byte offset bits dropped
  assign rd_idx = araddr[IDX_W+1:2];
  assign wr_idx = wr_addr[IDX_W+1:2];

  // ====================================================================
  // Program load port
  // ====================================================================

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // ====================================================================
  // Synchronous read
  // ====================================================================

  // Data register only moves on a fetch strobe
  // A stalled fetch keeps its word until the next strobe
  always_ff @(posedge clk) begin
    if (arvalid) begin
      rdata <= mem[rd_idx];
    end
  end

  // Marks rdata as freshly read in the previous cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= arvalid;
    end
  end

endmodule

//--- design/btb.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module btb (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              lookup_valid,
  input  rv_isa_pkg::addr_t lookup_pc,
  pred_if.btb               pred,
  input  logic              upd_en,
  input  rv_isa_pkg::addr_t upd_pc,
  input  rv_isa_pkg::addr_t upd_target,
  input  logic              upd_taken,
  input  logic              upd_is_return
);
  import fetch_pkg::*;

  btb_entry_t btb_mem [`BTB_ENTRIES];
  btb_entry_t lookup_entry;
  btb_entry_t upd_entry;
  btb_idx_t   upd_idx;
  logic       lookup_hit;

  // ====================================================================
  // Update port
  // ====================================================================

  // Whole line is rewritten, valid set
  assign upd_idx   = btb_index(upd_pc);
  assign upd_entry = '{
    valid:     1'b1,
    tag:       btb_tag(upd_pc),
    target:    upd_target,
    taken:     upd_taken,
    is_return: upd_is_return
  };

  // Only the valid bits are cleared, tags and targets are don't-care
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `BTB_ENTRIES; i++) begin
        btb_mem[i].valid <= 1'b0;
      end
    end else if (upd_en) begin
      btb_mem[upd_idx] <= upd_entry;
    end
  end

  // ====================================================================
  // Lookup
  // ====================================================================

  assign lookup_entry = btb_mem[btb_index(lookup_pc)];
  assign lookup_hit   = lookup_entry.valid && (lookup_entry.tag == btb_tag(lookup_pc));

  // Flags registered like memory rdata, held when no fetch strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred.hit        <= 1'b0;
      pred.pred_taken <= 1'b0;
      pred.is_return  <= 1'b0;
    end else if (lookup_valid) begin
      pred.hit        <= lookup_hit;
      pred.pred_taken <= lookup_hit && lookup_entry.taken;
      pred.is_return  <= lookup_hit && lookup_entry.is_return;
    end
  end

  // Target forced to zero on a miss so decode sees clean metadata
  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      pred.target <= lookup_hit ? lookup_entry.target : '0;
    end
  end

endmodule

//--- design/if_stage.sv
`timescale 1ns/1ns

module if_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush,
  input  rv_isa_pkg::instr_t rdata,
  input  logic               rvalid,
  input  rv_isa_pkg::addr_t  pc,
  pred_if.if_stage           pred,
  input  logic               m_ready,
  output logic               s_ready,
  output rv_isa_pkg::instr_t instr,
  output rv_isa_pkg::addr_t  pc_out,
  output rv_isa_pkg::addr_t  pc_plus4,
  output fetch_pkg::pred_t   pred_out,
  output logic               m_valid
);
  import rv_isa_pkg::*;
  import fetch_pkg::*;

  logic  flush_extend;
  logic  kill;
  addr_t pc_buf;
  pred_t pred_q;

  // Backpressure goes straight through to the sequencer
  assign s_ready = m_ready;

  // ====================================================================
  // Extended flush
  // ====================================================================

  // The word fetched on the redirect edge is the old sequential one
  // A second flush cycle drops it before it reaches decode
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flush_extend <= 1'b0;
    end else begin
      flush_extend <= flush;
    end
  end

  assign kill = !rst_n || flush || flush_extend;

  // ====================================================================
  // PC alignment
  // ====================================================================

  // Memory and BTB answer one cycle late, so the PC waits one cycle too
  always_ff @(posedge clk) begin
    if (m_ready) begin
      pc_buf <= pc;
    end
  end

  // ====================================================================
  // IF/ID register
  // ====================================================================

  // Bubble on kill, otherwise take the memory word on ready
  always_ff @(posedge clk) begin
    if (kill) begin
      instr <= I_NOP;
    end else if (m_ready) begin
      instr <= rdata;
    end
  end

  // Sets only when a fresh word arrives; stays set through stalls
  // Flush drops it regardless of ready
  always_ff @(posedge clk) begin
    if (kill) begin
      m_valid <= 1'b0;
    end else if (m_ready && rvalid) begin
      m_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (m_ready) begin
      pc_out   <= pc_buf;
      pc_plus4 <= pc_buf + addr_t'(4);
    end
  end

  // Prediction flags cleared with the bubble, target just follows
  always_ff @(posedge clk) begin
    if (m_ready) begin
      pred_q.target <= pred.target;
    end
    if (kill) begin
      pred_q.hit       <= 1'b0;
      pred_q.taken     <= 1'b0;
      pred_q.is_return <= 1'b0;
    end else if (m_ready) begin
      pred_q.hit       <= pred.hit;
      pred_q.taken     <= pred.pred_taken;
      pred_q.is_return <= pred.is_return;
    end
  end

  assign pred_out = pred_q;

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
  input  logic               clk,
  input  logic               rst_n,
  // Branch resolution from later stages
  input  logic               redirect,
  input  rv_isa_pkg::addr_t  redirect_pc,
  // Packet toward decode
  input  logic               m_ready,
  output logic               m_valid,
  output rv_isa_pkg::instr_t instr,
  output rv_isa_pkg::addr_t  pc,
  output rv_isa_pkg::addr_t  pc_plus4,
  output logic               pred_hit,
  output logic               pred_taken,
  output rv_isa_pkg::addr_t  pred_target,
  output logic               pred_is_return,
  // Program image load
  input  logic               imem_wr_en,
  input  rv_isa_pkg::addr_t  imem_wr_addr,
  input  rv_isa_pkg::instr_t imem_wr_data,
  // BTB training
  input  logic               btb_upd_en,
  input  rv_isa_pkg::addr_t  btb_upd_pc,
  input  rv_isa_pkg::addr_t  btb_upd_target,
  input  logic               btb_upd_taken,
  input  logic               btb_upd_is_return
);
  import rv_isa_pkg::*;
  import fetch_pkg::*;

  addr_t  fetch_addr;
  logic   fetch_valid;
  logic   fetch_ready;
  instr_t imem_rdata;
  logic   imem_rvalid;
  pred_t  pred_id;

  pred_if pred_bus ();

  // ====================================================================
  // Fetch address and parallel lookups
  // ====================================================================

  fetch_pc u_fetch_pc (
    .clk         (clk),
    .rst_n       (rst_n),
    .ready       (fetch_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (fetch_addr),
    .arvalid     (fetch_valid)
  );

  instr_mem u_instr_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .arvalid (fetch_valid),
    .araddr  (fetch_addr),
    .rdata   (imem_rdata),
    .rvalid  (imem_rvalid),
    .wr_en   (imem_wr_en),
    .wr_addr (imem_wr_addr),
    .wr_data (imem_wr_data)
  );

  btb u_btb (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookup_valid  (fetch_valid),
    .lookup_pc     (fetch_addr),
    .pred          (pred_bus.btb),
    .upd_en        (btb_upd_en),
    .upd_pc        (btb_upd_pc),
    .upd_target    (btb_upd_target),
    .upd_taken     (btb_upd_taken),
    .upd_is_return (btb_upd_is_return)
  );

  // ====================================================================
  // IF stage
  // ====================================================================

  // Redirect doubles as the IF flush
  if_stage u_if_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (redirect),
    .rdata    (imem_rdata),
    .rvalid   (imem_rvalid),
    .pc       (fetch_addr),
    .pred     (pred_bus.if_stage),
    .m_ready  (m_ready),
    .s_ready  (fetch_ready),
    .instr    (instr),
    .pc_out   (pc),
    .pc_plus4 (pc_plus4),
    .pred_out (pred_id),
    .m_valid  (m_valid)
  );

  // Flatten prediction metadata onto plain ports
  assign pred_hit       = pred_id.hit;
  assign pred_taken     = pred_id.taken;
  assign pred_target    = pred_id.target;
  assign pred_is_return = pred_id.is_return;

endmodule

//--- sim/tb_fetch.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module tb_fetch;
  import rv_isa_pkg::*;

  localparam int IDX_W = $clog2(`IMEM_WORDS);
  localparam int BTB_W = $clog2(`BTB_ENTRIES);

  // ======================================================================
  // DUT ports
  // ======================================================================

  logic   clk;
  logic   rst_n;
  logic   redirect;
  addr_t  redirect_pc;
  logic   m_ready;
  logic   m_valid;
  instr_t instr;
  addr_t  pc;
  addr_t  pc_plus4;
  logic   pred_hit;
  logic   pred_taken;
  addr_t  pred_target;
  logic   pred_is_return;
  logic   imem_wr_en;
  addr_t  imem_wr_addr;
  instr_t imem_wr_data;
  logic   btb_upd_en;
  addr_t  btb_upd_pc;
  addr_t  btb_upd_target;
  logic   btb_upd_taken;
  logic   btb_upd_is_return;

  // Reference model: program image, BTB lines, next expected PC
  instr_t model_mem [`IMEM_WORDS];
  logic   btb_valid [`BTB_ENTRIES];
  addr_t  btb_pc [`BTB_ENTRIES];
  addr_t  btb_target [`BTB_ENTRIES];
  logic   btb_taken [`BTB_ENTRIES];
  logic   btb_ret [`BTB_ENTRIES];
  addr_t  exp_pc;

  // Parsed trace lines, one entry per W/B/R/J line
  byte         kind_q [$];
  logic [31:0] a_q [$];
  logic [31:0] b_q [$];
  logic [31:0] c_q [$];
  logic [31:0] d_q [$];

  logic [31:0] rng;
  int          errors;
  int          transfers;
  int          run_total;
  logic        load_done;
  // Stall bookkeeping, outputs must not move while decode holds off
  logic        hold_armed;
  logic [31:0] snap [5];
  // Set by a redirect until the first transfer after it
  logic        pending;
  addr_t       pend_target;

  fetch_top dut0 (.*);

  always #20 clk = ~clk;

  // ======================================================================
  // Helpers
  // ======================================================================

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Background program word, mixes every bit of the byte address
  function automatic instr_t fill_word(input addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic read_trace;
    int    fd;
    int    n;
    string line;
    byte   kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    fd = $fopen("sim/fetch_trace.txt", "r");
    assert (fd != 0) else begin
      errors++;
      $display("Trace file sim/fetch_trace.txt could not be opened");
    end
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Comment and blank lines carry no data
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          a = '0;
          b = '0;
          c = '0;
          d = '0;
          n = $sscanf(line, "%c %h %h %h %h", kind, a, b, c, d);
          kind_q.push_back(kind);
          a_q.push_back(a);
          b_q.push_back(b);
          c_q.push_back(c);
          d_q.push_back(d);
          if (kind == "R") run_total += int'(a);
          if (kind == "J") run_total += 1;
        end
      end
      $fclose(fd);
    end
  endtask

  // Fill the model, then copy it through the load and update ports
  task automatic load_trace;
    addr_t            wa;
    logic [BTB_W-1:0] bi;
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      model_mem[i] = fill_word(addr_t'(i * 4));
    end
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
      btb_valid[i] = 1'b0;
    end
    foreach (kind_q[i]) begin
      wa = a_q[i];
      if (kind_q[i] == "W") model_mem[wa[IDX_W+1:2]] = b_q[i];
    end
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      @(negedge clk);
      imem_wr_en   = 1'b1;
      imem_wr_addr = addr_t'(i * 4);
      imem_wr_data = model_mem[i];
    end
    foreach (kind_q[i]) begin
      if (kind_q[i] == "B") begin
        @(negedge clk);
        imem_wr_en        = 1'b0;
        btb_upd_en        = 1'b1;
        btb_upd_pc        = a_q[i];
        btb_upd_target    = b_q[i];
        btb_upd_taken     = c_q[i][0];
        btb_upd_is_return = d_q[i][0];
        // Direct mapped, a later line overwrites the same index
        wa             = a_q[i];
        bi             = wa[BTB_W+1:2];
        btb_valid[bi]  = 1'b1;
        btb_pc[bi]     = a_q[i];
        btb_target[bi] = b_q[i];
        btb_taken[bi]  = c_q[i][0];
        btb_ret[bi]    = d_q[i][0];
      end
    end
    @(negedge clk);
    imem_wr_en = 1'b0;
    btb_upd_en = 1'b0;
  endtask

  // Packet accepted on the coming rising edge
  task automatic check_transfer;
    logic [BTB_W-1:0] bi;
    logic             hit;
    bi  = exp_pc[BTB_W+1:2];
    hit = btb_valid[bi]
          && (btb_pc[bi][`FETCH_XLEN-1:BTB_W+2] == exp_pc[`FETCH_XLEN-1:BTB_W+2]);
    transfers++;
    check_value("pc", pc, exp_pc);
    check_value("instr", instr, model_mem[exp_pc[IDX_W+1:2]]);
    check_value("pc_plus4", pc_plus4, exp_pc + 32'd4);
    check_value("pred_hit", 32'(pred_hit), 32'(hit));
    check_value("pred_taken", 32'(pred_taken), 32'(hit && btb_taken[bi]));
    check_value("pred_is_return", 32'(pred_is_return), 32'(hit && btb_ret[bi]));
    check_value("pred_target", pred_target, hit ? btb_target[bi] : '0);
    // Sequential fetch, next packet is one word further on
    exp_pc  = exp_pc + 32'd4;
    pending = 1'b0;
  endtask

  task automatic check_hold;
    check_value("m_valid held", 32'(m_valid), 32'd1);
    check_value("pc held", pc, snap[0]);
    check_value("instr held", instr, snap[1]);
    check_value("pc_plus4 held", pc_plus4, snap[2]);
    check_value("pred_target held", pred_target, snap[3]);
    check_value("pred flags held", {29'd0, pred_hit, pred_taken, pred_is_return}, snap[4]);
  endtask

  // One cycle of decode behavior, driven on the falling edge
  task automatic run_cycle(input logic redir, input addr_t tgt);
    logic rdy;
    @(negedge clk);
    if (hold_armed) check_hold();
    rng = xorshift(rng);
    // Decode holds ready high while the IF/ID slot is empty
    rdy         = !m_valid || (rng[1:0] != 2'b00);
    m_ready     = rdy;
    redirect    = redir;
    redirect_pc = tgt;
    if (m_valid && rdy) check_transfer();
    hold_armed = m_valid && !rdy && !redir;
    snap[0] = pc;
    snap[1] = instr;
    snap[2] = pc_plus4;
    snap[3] = pred_target;
    snap[4] = {29'd0, pred_hit, pred_taken, pred_is_return};
    if (redir) begin
      assert (!pending) else begin
        errors++;
        $display("Redirect to %h was never followed by a transfer", pend_target);
      end
      exp_pc      = tgt;
      pend_target = tgt;
      pending     = 1'b1;
    end
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial begin
    clk               = 1'b0;
    rst_n             = 1'b0;
    redirect          = 1'b0;
    redirect_pc       = '0;
    m_ready           = 1'b0;
    imem_wr_en        = 1'b0;
    imem_wr_addr      = '0;
    imem_wr_data      = '0;
    btb_upd_en        = 1'b0;
    btb_upd_pc        = '0;
    btb_upd_target    = '0;
    btb_upd_taken     = 1'b0;
    btb_upd_is_return = 1'b0;
    rng        = 32'd71;
    errors     = 0;
    transfers  = 0;
    run_total  = 0;
    load_done  = 1'b0;
    hold_armed = 1'b0;
    pending    = 1'b0;
    exp_pc     = `RESET_PC;
    read_trace();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    if (errors == 0) begin
      // Ready stays low during the load, so the PC waits at reset value
      load_trace();
      load_done = 1'b1;
      foreach (kind_q[i]) begin
        if (kind_q[i] == "R") begin
          repeat (int'(a_q[i])) run_cycle(1'b0, '0);
        end else if (kind_q[i] == "J") begin
          run_cycle(1'b1, a_q[i]);
        end
      end
      @(negedge clk);
      m_ready  = 1'b0;
      redirect = 1'b0;
      assert (!pending) else begin
        errors++;
        $display("Redirect to %h was never followed by a transfer", pend_target);
      end
      assert (transfers > 0) else begin
        errors++;
        $display("No packet was transferred to decode");
      end
    end
    $display("Transfers %0d, errors %0d", transfers, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the trace run length
  initial begin
    wait (load_done);
    #((run_total + 200) * 40);
    $display("Timeout after %0d run cycles without reaching the end", run_total + 200);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- sim/fetch_trace.txt
# W word_addr instr | B pc target taken is_return | all hex
# R run_cycles | J redirect_pc | all hex
W 00000004 00a00093
W 00000100 fe000ee3
B 00000008 00000040 1 0
B 00000044 00000100 0 1
B 0000010c 00000010 1 0
R 28
J 00000100
R 28
J 00000044
R 30

//--- files.f
+incdir+design
design/rv_isa_pkg.sv
design/fetch_pkg.sv
design/pred_if.sv
design/fetch_pc.sv
design/instr_mem.sv
design/btb.sv
design/if_stage.sv
design/fetch_top.sv
sim/tb_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the fetch testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_fetch -f files.f -o tb_fetch_sim \
  && ./obj_dir/tb_fetch_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
